// ==== verilog/muldiv_pkg.sv ====
package muldiv_pkg;

    localparam int xlen      = 32;
    localparam int div_iters = xlen;   // One quotient bit per cycle

    typedef logic [xlen-1:0] word_t;

    // Iteration counter of the divider, wide enough to hold div_iters
    typedef logic [$clog2(div_iters + 1)-1:0] div_cnt_t;

    // Bit 2 selects divide
    // Divides use bit 1 for remainder and bit 0 for unsigned
    typedef enum logic [2:0] {
        op_mul    = 3'b000,
        op_mulh   = 3'b001,
        op_mulhsu = 3'b010,
        op_mulhu  = 3'b011,
        op_div    = 3'b100,
        op_divu   = 3'b101,
        op_rem    = 3'b110,
        op_remu   = 3'b111
    } muldiv_op_e;

    // Operand flags from the classifier
    typedef struct packed {
        logic b_m1;
        logic b_one;
        logic b_zero;
        logic a_m1;
        logic a_one;
        logic a_zero;
    } ab_status_t;

    typedef enum logic [1:0] {
        src_fast = 2'd0,
        src_mul  = 2'd1,
        src_div  = 2'd2
    } res_src_e;

endpackage

// ==== verilog/div_if.sv ====
`timescale 1ns/10ps

interface div_if;

    logic              div_start;   // Held until div_rdy
    logic              div_signed;
    logic              want_rem;
    muldiv_pkg::word_t dividend;
    muldiv_pkg::word_t divisor;
    logic              div_rdy;     // One-cycle pulse
    muldiv_pkg::word_t div_result;

    modport ctrl (
        output div_start, div_signed, want_rem, dividend, divisor,
        input  div_rdy, div_result
    );

    modport div (
        input  div_start, div_signed, want_rem, dividend, divisor,
        output div_rdy, div_result
    );

endinterface

// ==== verilog/operand_classify.sv ====
`timescale 1ns/10ps

module operand_classify (
    input  muldiv_pkg::word_t      a,
    input  muldiv_pkg::word_t      b,
    output muldiv_pkg::word_t      a_neg,
    output muldiv_pkg::word_t      b_neg,
    output muldiv_pkg::ab_status_t status
);

    localparam muldiv_pkg::word_t one = muldiv_pkg::word_t'(1);

    // Two's complements, used by the minus-one shortcuts
    assign a_neg = ~a + one;
    assign b_neg = ~b + one;

    always_comb begin
        status.a_zero = (a == '0);
        status.a_one  = (a == one);
        status.a_m1   = &a;          // All ones
        status.b_zero = (b == '0);
        status.b_one  = (b == one);
        status.b_m1   = &b;
    end

endmodule

// ==== verilog/muldiv_ctrl.sv ====
`timescale 1ns/10ps

module muldiv_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  muldiv_pkg::muldiv_op_e op,
    input  muldiv_pkg::ab_status_t status,
    input  muldiv_pkg::word_t      a_reg,
    input  muldiv_pkg::word_t      b_reg,
    input  muldiv_pkg::word_t      a_neg,
    input  muldiv_pkg::word_t      b_neg,
    input  logic                   mul_rdy,
    output logic                   ab_en,
    output muldiv_pkg::res_src_e   res_src,
    output muldiv_pkg::word_t      fast_result,
    output logic                   done,
    output logic                   ready,
    div_if.ctrl                    div
);

    typedef enum logic [2:0] {
        st_idle,
        st_div,
        st_div_out,
        st_mul1,
        st_mul2,
        st_mul_out
    } state_e;

    state_e state;
    state_e next_state;
    logic   fast_hit;
    logic   a_msb;
    logic   b_msb;

    assign a_msb = a_reg[muldiv_pkg::xlen-1];
    assign b_msb = b_reg[muldiv_pkg::xlen-1];

    // Fast results; checks run in priority order, first match wins
    always_comb begin
        fast_hit    = 1'b1;
        fast_result = '0;
        if (!op[2]) begin
            if (status.a_zero || status.b_zero) begin
                fast_result = '0;
            end else if (status.a_one) begin
                case (op)
                    muldiv_pkg::op_mul:  fast_result = b_reg;
                    muldiv_pkg::op_mulh: fast_result = {muldiv_pkg::xlen{b_msb}};
                    default:             fast_result = '0;   // b unsigned, high word empty
                endcase
            end else if (status.b_one) begin
                case (op)
                    muldiv_pkg::op_mul:    fast_result = a_reg;
                    muldiv_pkg::op_mulh,
                    muldiv_pkg::op_mulhsu: fast_result = {muldiv_pkg::xlen{a_msb}};
                    default:               fast_result = '0;
                endcase
            end else if (status.a_m1) begin
                // Product is -b, b known nonzero
                case (op)
                    muldiv_pkg::op_mul:    fast_result = b_neg;
                    muldiv_pkg::op_mulh:   fast_result = {muldiv_pkg::xlen{~b_msb}};
                    muldiv_pkg::op_mulhsu: fast_result = '1;
                    default:               fast_hit = 1'b0;  // MULHU needs the engine
                endcase
            end else if (status.b_m1) begin
                case (op)
                    muldiv_pkg::op_mul:    fast_result = a_neg;
                    muldiv_pkg::op_mulh:   fast_result = {muldiv_pkg::xlen{~a_msb}};
                    // a * (2^xlen - 1) keeps a when negative, a - 1 otherwise
                    muldiv_pkg::op_mulhsu: fast_result = a_msb ? a_reg : ~a_neg;
                    default:               fast_hit = 1'b0;
                endcase
            end else begin
                fast_hit = 1'b0;
            end
        end else begin
            if (status.b_zero) begin
                fast_result = op[1] ? a_reg : '1;            // Divide by zero
            end else if (status.a_zero) begin
                fast_result = '0;
            end else if (status.b_one) begin
                fast_result = op[1] ? '0 : a_reg;
            end else if (status.b_m1) begin
                if (op[0])
                    fast_hit = 1'b0;
                else
                    fast_result = op[1] ? '0 : a_neg;        // Overflow wraps to a
            end else if (status.a_m1) begin
                if (op[0])
                    fast_hit = 1'b0;
                else
                    fast_result = op[1] ? a_reg : '0;        // |b| > 1, rem is -1
            end else if (status.a_one) begin
                fast_result = op[1] ? a_reg : '0;
            end else begin
                fast_hit = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_comb begin
        next_state    = state;
        ab_en         = 1'b0;
        done          = 1'b0;
        res_src       = muldiv_pkg::src_fast;
        div.div_start = 1'b0;
        case (state)
            st_idle: begin
                if (start) begin
                    if (fast_hit) begin
                        done = 1'b1;                         // Same cycle as start
                    end else begin
                        ab_en      = 1'b1;
                        next_state = op[2] ? st_div : st_mul1;
                    end
                end
            end
            st_div: begin
                if (div.div_rdy)
                    next_state = st_div_out;
                else
                    div.div_start = 1'b1;
            end
            st_div_out: begin
                res_src    = muldiv_pkg::src_div;
                done       = 1'b1;
                next_state = st_idle;
            end
            st_mul1:    next_state = st_mul2;
            st_mul2:    next_state = st_mul_out;
            st_mul_out: begin
                res_src = muldiv_pkg::src_mul;
                if (mul_rdy) begin
                    done       = 1'b1;
                    next_state = st_idle;
                end
            end
            default:    next_state = st_idle;
        endcase
    end

    assign ready = (state == st_idle);

    // Divider operands come straight from the registered values
    assign div.div_signed = ~op[0];
    assign div.want_rem   = op[1];
    assign div.dividend   = a_reg;
    assign div.divisor    = b_reg;

endmodule

// ==== verilog/mul_pipe.sv ====
`timescale 1ns/10ps

module mul_pipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mul_start,
    input  muldiv_pkg::word_t      a,
    input  muldiv_pkg::word_t      b,
    input  muldiv_pkg::muldiv_op_e mul_op,
    output muldiv_pkg::word_t      product,
    output logic                   mul_rdy
);

    logic                                a_signed;
    logic                                b_signed;
    logic [muldiv_pkg::xlen:0]           a_ext;
    logic [muldiv_pkg::xlen:0]           b_ext;
    logic signed [2*muldiv_pkg::xlen+1:0] prod_full;
    logic                                s1_hi;
    logic                                op_valid;   // Operands sit in the top registers
    logic                                s1_valid;

    // a is signed for all but MULHU, b only for MUL and MULH
    assign a_signed = (mul_op != muldiv_pkg::op_mulhu);
    assign b_signed = (mul_op == muldiv_pkg::op_mul) || (mul_op == muldiv_pkg::op_mulh);

    assign a_ext = {a_signed & a[muldiv_pkg::xlen-1], a};
    assign b_ext = {b_signed & b[muldiv_pkg::xlen-1], b};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            op_valid <= 1'b0;
            s1_valid <= 1'b0;
            mul_rdy  <= 1'b0;
        end else begin
            op_valid <= mul_start;
            s1_valid <= op_valid;
            mul_rdy  <= s1_valid;
        end
    end

    // Stage one, full 33x33 product
    always_ff @(posedge clk) begin
        if (op_valid) begin
            prod_full <= $signed(a_ext) * $signed(b_ext);
            s1_hi     <= (mul_op != muldiv_pkg::op_mul);
        end
    end

    // Stage two, word select
    always_ff @(posedge clk) begin
        if (s1_valid)
            product <= s1_hi ? prod_full[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen]
                             : prod_full[muldiv_pkg::xlen-1:0];
    end

endmodule

// ==== verilog/div_iter.sv ====
`timescale 1ns/10ps

module div_iter (
    input logic clk,
    input logic reset,
    div_if.div  div
);

    logic                      busy;
    logic                      fin;
    logic                      load;
    muldiv_pkg::div_cnt_t      count;
    muldiv_pkg::word_t         rem;
    muldiv_pkg::word_t         quo;      // Holds the dividend, shifts out as quotient shifts in
    muldiv_pkg::word_t         divr;
    logic                      neg_q;
    logic                      neg_r;
    logic                      want_rem_q;
    logic [muldiv_pkg::xlen:0] shift_rem;
    logic [muldiv_pkg::xlen:0] trial;
    muldiv_pkg::word_t         q_fix;
    muldiv_pkg::word_t         r_fix;
    logic                      a_msb;
    logic                      b_msb;

    assign a_msb = div.dividend[muldiv_pkg::xlen-1];
    assign b_msb = div.divisor[muldiv_pkg::xlen-1];
    assign load  = div.div_start && !busy && !fin;

    // Restoring step, borrow out of the top bit means restore
    assign shift_rem = {rem, quo[muldiv_pkg::xlen-1]};
    assign trial     = shift_rem - {1'b0, divr};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy  <= 1'b0;
            fin   <= 1'b0;
            count <= '0;
        end else begin
            fin <= 1'b0;
            if (load) begin
                busy  <= 1'b1;
                count <= muldiv_pkg::div_cnt_t'(muldiv_pkg::div_iters);
            end else if (busy) begin
                count <= count - 1'b1;
                if (count == muldiv_pkg::div_cnt_t'(1)) begin
                    busy <= 1'b0;
                    fin  <= 1'b1;   // Last quotient bit goes in this edge
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rem        <= '0;
            quo        <= (div.div_signed && a_msb) ? -div.dividend : div.dividend;
            divr       <= (div.div_signed && b_msb) ? -div.divisor : div.divisor;
            neg_q      <= div.div_signed && (a_msb ^ b_msb);
            neg_r      <= div.div_signed && a_msb;   // Remainder takes the dividend sign
            want_rem_q <= div.want_rem;
        end else if (busy) begin
            if (!trial[muldiv_pkg::xlen]) begin
                rem <= trial[muldiv_pkg::xlen-1:0];
                quo <= {quo[muldiv_pkg::xlen-2:0], 1'b1};
            end else begin
                rem <= shift_rem[muldiv_pkg::xlen-1:0];
                quo <= {quo[muldiv_pkg::xlen-2:0], 1'b0};
            end
        end
    end

    // Sign fix and select, held stable until the next load
    assign q_fix = neg_q ? -quo : quo;
    assign r_fix = neg_r ? -rem : rem;

    assign div.div_result = want_rem_q ? r_fix : q_fix;
    assign div.div_rdy    = fin;

endmodule

// ==== verilog/muldiv_unit.sv ====
`timescale 1ns/10ps

module muldiv_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  muldiv_pkg::muldiv_op_e op,
    input  muldiv_pkg::word_t      a,
    input  muldiv_pkg::word_t      b,
    output logic                   ready,
    output logic                   done,
    output muldiv_pkg::word_t      result
);

    muldiv_pkg::word_t      a_reg;
    muldiv_pkg::word_t      b_reg;
    muldiv_pkg::muldiv_op_e op_reg;
    muldiv_pkg::word_t      a_sel;
    muldiv_pkg::word_t      b_sel;
    muldiv_pkg::muldiv_op_e op_sel;
    muldiv_pkg::word_t      a_neg;
    muldiv_pkg::word_t      b_neg;
    muldiv_pkg::ab_status_t status;
    muldiv_pkg::res_src_e   res_src;
    muldiv_pkg::word_t      fast_result;
    muldiv_pkg::word_t      product;
    logic                   ab_en;
    logic                   mul_rdy;

    div_if div_bus ();

    // Operand and op capture for the engine paths
    always_ff @(posedge clk) begin
        if (ab_en) begin
            a_reg  <= a;
            b_reg  <= b;
            op_reg <= op;
        end
    end

    // Live inputs in the start cycle, captured values while busy
    assign a_sel  = ready ? a : a_reg;
    assign b_sel  = ready ? b : b_reg;
    assign op_sel = ready ? op : op_reg;

    operand_classify classify_i (
        .a      (a_sel),
        .b      (b_sel),
        .a_neg  (a_neg),
        .b_neg  (b_neg),
        .status (status)
    );

    muldiv_ctrl ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .op          (op_sel),
        .status      (status),
        .a_reg       (a_sel),
        .b_reg       (b_sel),
        .a_neg       (a_neg),
        .b_neg       (b_neg),
        .mul_rdy     (mul_rdy),
        .ab_en       (ab_en),
        .res_src     (res_src),
        .fast_result (fast_result),
        .done        (done),
        .ready       (ready),
        .div         (div_bus.ctrl)
    );

    mul_pipe mul_i (
        .clk       (clk),
        .reset     (reset),
        .mul_start (ab_en && !op_sel[2]),   // Engine multiply accepted
        .a         (a_reg),
        .b         (b_reg),
        .mul_op    (op_reg),
        .product   (product),
        .mul_rdy   (mul_rdy)
    );

    div_iter div_i (
        .clk   (clk),
        .reset (reset),
        .div   (div_bus.div)
    );

    always_comb begin
        case (res_src)
            muldiv_pkg::src_mul: result = product;
            muldiv_pkg::src_div: result = div_bus.div_result;
            default:             result = fast_result;
        endcase
    end

endmodule

// ==== sim/muldiv_model.svh ====
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// Reference result of one operation, M extension rules
function automatic muldiv_pkg::word_t expected_result(input muldiv_pkg::muldiv_op_e op_v,
                                                      input muldiv_pkg::word_t      a_v,
                                                      input muldiv_pkg::word_t      b_v);
    logic signed [2*muldiv_pkg::xlen-1:0] sa;
    logic signed [2*muldiv_pkg::xlen-1:0] sb;
    logic signed [2*muldiv_pkg::xlen-1:0] ua;
    logic signed [2*muldiv_pkg::xlen-1:0] ub;
    logic signed [2*muldiv_pkg::xlen-1:0] prod;
    logic                                 by_zero;
    logic                                 overflow;
    sa       = {{muldiv_pkg::xlen{a_v[muldiv_pkg::xlen-1]}}, a_v};
    sb       = {{muldiv_pkg::xlen{b_v[muldiv_pkg::xlen-1]}}, b_v};
    ua       = {{muldiv_pkg::xlen{1'b0}}, a_v};    // Zero extended, still positive
    ub       = {{muldiv_pkg::xlen{1'b0}}, b_v};
    by_zero  = (b_v == '0);
    overflow = (a_v == {1'b1, {(muldiv_pkg::xlen-1){1'b0}}}) && (b_v == '1);
    case (op_v)
        muldiv_pkg::op_mul,
        muldiv_pkg::op_mulh:   prod = sa * sb;
        muldiv_pkg::op_mulhsu: prod = sa * ub;
        muldiv_pkg::op_mulhu:  prod = ua * ub;    // Low 64 bits are exact modulo 2^64
        default:               prod = '0;
    endcase
    case (op_v)
        muldiv_pkg::op_mul:    return prod[muldiv_pkg::xlen-1:0];
        muldiv_pkg::op_mulh,
        muldiv_pkg::op_mulhsu,
        muldiv_pkg::op_mulhu:  return prod[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen];
        muldiv_pkg::op_div:    return by_zero ? '1 : overflow ? a_v : muldiv_pkg::word_t'(sa / sb);
        muldiv_pkg::op_divu:   return by_zero ? '1 : muldiv_pkg::word_t'(ua / ub);
        muldiv_pkg::op_rem:    return by_zero ? a_v : overflow ? '0 : muldiv_pkg::word_t'(sa % sb);
        muldiv_pkg::op_remu:   return by_zero ? a_v : muldiv_pkg::word_t'(ua % ub);
        default:               return '0;
    endcase
endfunction

// Whether the unit answers in the start cycle without an engine
function automatic bit takes_fast_path(input muldiv_pkg::muldiv_op_e op_v,
                                       input muldiv_pkg::word_t      a_v,
                                       input muldiv_pkg::word_t      b_v);
    bit zero_or_one;
    bit m1;
    zero_or_one = (a_v == 0) || (a_v == 1) || (b_v == 0) || (b_v == 1);
    m1          = (a_v == '1) || (b_v == '1);
    if (!op_v[2])
        return zero_or_one || (m1 && op_v != muldiv_pkg::op_mulhu);
    if ((b_v == 0) || (a_v == 0) || (b_v == 1))
        return 1'b1;
    if (m1)
        return !op_v[0];   // Unsigned divides keep minus one on the engine
    return a_v == 1;
endfunction

`endif

// ==== sim/muldiv_tb.sv ====
`timescale 1ns/10ps

module muldiv_tb;

    `include "muldiv_model.svh"

    typedef struct packed {
        muldiv_pkg::muldiv_op_e op;
        muldiv_pkg::word_t      a;
        muldiv_pkg::word_t      b;
        logic                   fast;   // Expected to finish in the start cycle
    } vec_t;

    localparam int n_table    = 30;
    localparam int n_random   = 200;
    localparam int clk_period = 10;
    // Worst case divide per operation plus reset slack
    localparam int limit_cycles = (n_table + n_random) * (muldiv_pkg::div_iters + 5) + 20;

    logic                   clk;
    logic                   reset;
    logic                   start;
    muldiv_pkg::muldiv_op_e op;
    muldiv_pkg::word_t      a;
    muldiv_pkg::word_t      b;
    logic                   ready;
    logic                   done;
    muldiv_pkg::word_t      result;
    integer                 seed;

    vec_t vecs [n_table] = '{
        // General multiplies
        '{muldiv_pkg::op_mul,    32'h1234_5678, 32'h9abc_def0, 1'b0},
        '{muldiv_pkg::op_mul,    32'h8000_0000, 32'h8000_0000, 1'b0},
        '{muldiv_pkg::op_mulh,   32'h8000_0000, 32'h7fff_ffff, 1'b0},
        '{muldiv_pkg::op_mulh,   32'hffff_fff0, 32'hffff_fff3, 1'b0},
        '{muldiv_pkg::op_mulhsu, 32'h8765_4321, 32'hffff_fffe, 1'b0},
        '{muldiv_pkg::op_mulhu,  32'hffff_fffe, 32'hffff_fffd, 1'b0},
        // General divides and remainders
        '{muldiv_pkg::op_div,    32'h8000_0000, 32'h0000_0007, 1'b0},
        '{muldiv_pkg::op_div,    32'h0000_0064, 32'hffff_fff9, 1'b0},
        '{muldiv_pkg::op_divu,   32'hffff_fff0, 32'h0000_0003, 1'b0},
        '{muldiv_pkg::op_rem,    32'hffff_ff9c, 32'h0000_0007, 1'b0},
        '{muldiv_pkg::op_remu,   32'h8765_4321, 32'h0000_1234, 1'b0},
        '{muldiv_pkg::op_rem,    32'h8000_0000, 32'hffff_fffe, 1'b0},
        // Zero, one and minus one shortcuts
        '{muldiv_pkg::op_mul,    32'h0000_0000, 32'h0000_1234, 1'b1},
        '{muldiv_pkg::op_mulh,   32'h1234_5678, 32'h0000_0000, 1'b1},
        '{muldiv_pkg::op_mulh,   32'h0000_0001, 32'h8765_4321, 1'b1},
        '{muldiv_pkg::op_mulhsu, 32'h8765_4321, 32'h0000_0001, 1'b1},
        '{muldiv_pkg::op_mulh,   32'hffff_ffff, 32'h8000_0000, 1'b1},
        '{muldiv_pkg::op_mulhsu, 32'hffff_ffff, 32'h0000_0005, 1'b1},
        '{muldiv_pkg::op_mulhsu, 32'h8000_0000, 32'hffff_ffff, 1'b1},
        '{muldiv_pkg::op_rem,    32'h1234_5678, 32'h0000_0001, 1'b1},
        '{muldiv_pkg::op_rem,    32'hffff_ffff, 32'h0000_0010, 1'b1},
        '{muldiv_pkg::op_remu,   32'h0000_0001, 32'h0000_0003, 1'b1},
        '{muldiv_pkg::op_div,    32'h1234_5678, 32'hffff_ffff, 1'b1},
        // Divide by zero and signed overflow
        '{muldiv_pkg::op_div,    32'h1234_5678, 32'h0000_0000, 1'b1},
        '{muldiv_pkg::op_remu,   32'h8765_4321, 32'h0000_0000, 1'b1},
        '{muldiv_pkg::op_div,    32'h8000_0000, 32'hffff_ffff, 1'b1},
        '{muldiv_pkg::op_rem,    32'h8000_0000, 32'hffff_ffff, 1'b1},
        // Unsigned minus one goes to the engines
        '{muldiv_pkg::op_mulhu,  32'hffff_ffff, 32'h1234_5678, 1'b0},
        '{muldiv_pkg::op_divu,   32'h1234_5678, 32'hffff_ffff, 1'b0},
        '{muldiv_pkg::op_remu,   32'hffff_ffff, 32'h0000_0007, 1'b0}
    };

    muldiv_unit muldiv_unit_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .ready  (ready),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_result(input muldiv_pkg::word_t got, input muldiv_pkg::word_t exp,
                                input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s result %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Mismatch at %0t: %s done after %0d cycles, expected %0d",
                     $time, what, got, exp);
            abort_run();
        end
    endtask

    // One operation, with a second start while busy that must be ignored
    task automatic run_op(input muldiv_pkg::muldiv_op_e op_v, input muldiv_pkg::word_t a_v,
                          input muldiv_pkg::word_t b_v, output muldiv_pkg::word_t res,
                          output int lat);
        bit seen;
        lat = 0;
        @(posedge clk);
        start <= 1'b1;
        op    <= op_v;
        a     <= a_v;
        b     <= b_v;
        @(negedge clk);
        if (!ready) begin
            $display("Unit not ready when a new operation starts at %0t", $time);
            abort_run();
        end
        seen = done;
        res  = result;
        @(posedge clk);
        start <= !seen;
        op    <= muldiv_pkg::muldiv_op_e'(op_v ^ 3'b100);
        a     <= ~a_v;
        b     <= b_v ^ 32'h00ff_0f0f;
        while (!seen) begin
            @(negedge clk);
            lat  = lat + 1;
            seen = done;
            res  = result;
            @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        if (done || !ready) begin
            $display("Extra done pulse or unit busy after an operation at %0t", $time);
            abort_run();
        end
    endtask

    task automatic grade_op(input muldiv_pkg::muldiv_op_e op_v, input muldiv_pkg::word_t a_v,
                            input muldiv_pkg::word_t b_v, input bit fast_v,
                            input muldiv_pkg::word_t res, input int lat);
        string what;
        what = $sformatf("%s a=%h b=%h", op_v.name(), a_v, b_v);
        check_result(res, expected_result(op_v, a_v, b_v), what);
        if (fast_v)
            check_latency(lat, 0, what);
        else if (!op_v[2])
            check_latency(lat, 3, what);
        else if (lat == 0) begin
            $display("Mismatch at %0t: %s finished in the start cycle", $time, what);
            abort_run();
        end
    endtask

    function automatic muldiv_pkg::word_t pick_operand(input muldiv_pkg::word_t rnd,
                                                       input logic [3:0]        sel);
        case (sel)
            4'd0:    return '0;
            4'd1:    return muldiv_pkg::word_t'(1);
            4'd2:    return '1;
            4'd3:    return {1'b1, {(muldiv_pkg::xlen-1){1'b0}}};   // Most negative
            default: return rnd;
        endcase
    endfunction

    initial begin
        #(limit_cycles * clk_period);
        $display("Timeout, no result from the unit within %0d cycles", limit_cycles);
        abort_run();
    end

    initial begin
        muldiv_pkg::word_t      res;
        muldiv_pkg::word_t      a_v;
        muldiv_pkg::word_t      b_v;
        muldiv_pkg::muldiv_op_e op_v;
        logic [31:0]            r;
        int                     lat;
        reset = 1'b0;
        start = 1'b0;
        op    = muldiv_pkg::op_mul;
        a     = '0;
        b     = '0;
        seed  = 32'h8971;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        if (!ready || done) begin
            $display("Unit not idle after reset");
            abort_run();
        end
        foreach (vecs[i]) begin
            run_op(vecs[i].op, vecs[i].a, vecs[i].b, res, lat);
            grade_op(vecs[i].op, vecs[i].a, vecs[i].b, vecs[i].fast, res, lat);
        end
        // Random ops, operands mixed with the shortcut values
        for (int n = 0; n < n_random; n++) begin
            r    = $random(seed);
            op_v = muldiv_pkg::muldiv_op_e'(r[2:0]);
            a_v  = pick_operand($random(seed), r[7:4]);
            b_v  = pick_operand($random(seed), r[11:8]);
            run_op(op_v, a_v, b_v, res, lat);
            grade_op(op_v, a_v, b_v, takes_fast_path(op_v, a_v, b_v), res, lat);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+sim
verilog/muldiv_pkg.sv
verilog/div_if.sv
verilog/operand_classify.sv
verilog/muldiv_ctrl.sv
verilog/mul_pipe.sv
verilog/div_iter.sv
verilog/muldiv_unit.sv
sim/muldiv_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       := muldiv_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
